/* Makefile */
# Verilator build and run of timebase_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run timebase_tb, search sim.log for failure"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   this list"

obj_dir/Vtimebase_tb: sysclk_timebase.f $(wildcard src/*.sv test/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module timebase_tb \
		-f sysclk_timebase.f

test: obj_dir/Vtimebase_tb
	./obj_dir/Vtimebase_tb +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	@if grep -q "TB FAILED" sim.log; then echo "test failed"; exit 1; fi
	@grep -q "TB PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
	@echo "test passed"

clean:
	rm -rf obj_dir sim.log

/* src/lock_monitor.sv */
// synchronizes and filters the pll lock level and counts lock losses for the reset sequencer
`timescale 1ns/100ps

module lock_monitor import timebase_pkg::*; #(
	parameter int LOCK_FILTER = 8	// cycles the synced lock must stay high
) (
	input  logic         sys_clk,
	input  logic         rst,
	input  logic         pll_locked,	// async level from the pll
	output lock_status_t lock_stat
);

	localparam hold_cnt_t FILTER_MAX = hold_cnt_t'(LOCK_FILTER);

	// ==================================================
	// two-flop synchronizer
	// ==================================================
	logic sync_meta;	// first stage, may go metastable
	logic sync_lock;	// second stage, safe to use

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			sync_meta <= 1'b0;
			sync_lock <= 1'b0;
		end else begin
			sync_meta <= pll_locked;
			sync_lock <= sync_meta;
		end
	end

	// ==================================================
	// stability filter
	// ==================================================
	hold_cnt_t filt_cnt;	// consecutive high samples, sticks at FILTER_MAX
	logic      locked_q;
	logic      lost_q;

	always_ff @(posedge sys_clk) begin
		if (rst) begin
			filt_cnt <= '0;
			locked_q <= 1'b0;
			lost_q   <= 1'b0;
		end else begin
			if (!sync_lock)
				filt_cnt <= '0;					// any low sample restarts the filter
			else if (filt_cnt != FILTER_MAX)
				filt_cnt <= filt_cnt + 1'b1;

			// lock only after the full filter run, drop on the first low sample
			if (!sync_lock)
				locked_q <= 1'b0;
			else if (filt_cnt == FILTER_MAX)
				locked_q <= 1'b1;

			lost_q <= locked_q & ~sync_lock;	// falls with locked_q, one cycle
		end
	end

	// ==================================================
	// lock loss counter
	// ==================================================
	loss_cnt_t loss_q;

	always_ff @(posedge sys_clk) begin
		if (rst)
			loss_q <= '0;						// only rst clears it
		else if (locked_q && !sync_lock && loss_q != '1)
			loss_q <= loss_q + 1'b1;			// lands with lost_q, sticks at 255
	end

	assign lock_stat = '{
		locked:     locked_q,
		lock_lost:  lost_q,
		loss_count: loss_q
	};

endmodule

/* src/reset_sequencer.sv */
// holds the system reset until a stable lock plus a hold time, then enables the tick generators
`timescale 1ns/100ps

module reset_sequencer import timebase_pkg::*; #(
	parameter int HOLD_CYCLES = 20	// cycles in SEQ_HOLD before release, at least 1
) (
	input  logic sys_clk,
	input  logic rst,
	input  logic locked,		// filtered lock level
	input  logic lock_lost,		// one cycle on loss of a stable lock
	output logic sys_rst,		// system reset, active high
	output logic tick_run		// tick generator enable
);

	// counter starts at HOLD_CYCLES-1 so SEQ_HOLD lasts exactly HOLD_CYCLES cycles
	localparam hold_cnt_t HOLD_LOAD = hold_cnt_t'(HOLD_CYCLES - 1);

	seq_state_t state;
	seq_state_t state_nx;
	hold_cnt_t  hold_cnt;		// down counter in SEQ_HOLD
	hold_cnt_t  hold_nx;

	// ==================================================
	// next state
	// ==================================================
	always_comb begin
		state_nx = state;
		hold_nx  = hold_cnt;

		case (state)
			SEQ_WAIT_LOCK: begin
				if (locked) begin
					state_nx = SEQ_HOLD;
					hold_nx  = HOLD_LOAD;
				end
			end

			SEQ_HOLD: begin
				if (hold_cnt == '0)
					state_nx = SEQ_RUN;		// hold done, release next edge
				else
					hold_nx = hold_cnt - 1'b1;
			end

			SEQ_RUN: begin
				state_nx = SEQ_RUN;			// stays here until lock drops
			end

			default: begin
				state_nx = SEQ_WAIT_LOCK;	// illegal encoding, start over
			end
		endcase

		// lock loss wins from any state
		if (lock_lost)
			state_nx = SEQ_WAIT_LOCK;
	end

	// ==================================================
	// state and output registers
	// ==================================================
	// outputs follow state_nx so they change on the same edge as the state
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			state    <= SEQ_WAIT_LOCK;
			hold_cnt <= '0;
			sys_rst  <= 1'b1;	// system held in reset out of rst
			tick_run <= 1'b0;
		end else begin
			state    <= state_nx;
			hold_cnt <= hold_nx;
			sys_rst  <= (state_nx != SEQ_RUN);
			tick_run <= (state_nx == SEQ_RUN);	// enabled exactly while out of reset
		end
	end

endmodule

/* src/tick_gen.sv */
// period counter producing a one-cycle tick and a stretched pulse; one instance per timebase rate
`timescale 1ns/100ps

module tick_gen import timebase_pkg::*; #(
	parameter tick_cnt_t DIVISOR = 30,	// sys_clk cycles per period
	parameter int        STRETCH = 10	// pulse starts STRETCH counts before terminal
) (
	input  logic sys_clk,
	input  logic rst,
	input  logic run,		// counting enable from the sequencer
	output logic tick,		// one cycle at count == DIVISOR
	output logic pulse		// high for count >= DIVISOR-STRETCH
);

	// first count of the stretched pulse, clamped for short periods
	localparam tick_cnt_t PULSE_START = (DIVISOR > STRETCH) ?
		tick_cnt_t'(DIVISOR - STRETCH) : tick_cnt_t'(1);

	tick_cnt_t cnt;		// runs 1..DIVISOR
	tick_cnt_t cnt_nx;
	logic      tick_q;
	logic      pulse_q;

	// rests at 1 when idle, reloads to 1 after terminal count
	always_comb begin
		if (!run)
			cnt_nx = tick_cnt_t'(1);
		else if (cnt == DIVISOR)
			cnt_nx = tick_cnt_t'(1);
		else
			cnt_nx = cnt + 1'b1;
	end

	// compare on the next count so the registered flags line up with cnt
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			cnt     <= tick_cnt_t'(1);
			tick_q  <= 1'b0;
			pulse_q <= 1'b0;
		end else begin
			cnt     <= cnt_nx;
			tick_q  <= run & (cnt_nx == DIVISOR);
			pulse_q <= run & (cnt_nx >= PULSE_START);
		end
	end

	// silent as soon as run drops
	assign tick  = tick_q & run;
	assign pulse = pulse_q & run;

endmodule

/* src/timebase_pkg.sv */
// shared widths, sequencer states and status/tick bundles; imported by every timebase module
package timebase_pkg;

	// ==================================================
	// counter widths
	// ==================================================
	typedef logic [31:0] tick_cnt_t;	// period counter, holds CLK_FREQ/30 at 100 MHz+
	typedef logic [15:0] hold_cnt_t;	// lock filter and reset hold counters
	typedef logic [7:0]  loss_cnt_t;	// lock losses, saturates at 255

	// ==================================================
	// reset sequencer states
	// ==================================================
	typedef enum logic [1:0] {
		SEQ_WAIT_LOCK = 2'd0,	// waiting for a filtered, stable lock
		SEQ_HOLD      = 2'd1,	// lock seen, counting out the reset hold
		SEQ_RUN       = 2'd2	// system out of reset, ticks running
	} seq_state_t;

	// ==================================================
	// bundles
	// ==================================================

	// lock monitor output, also passed out of the top as status
	typedef struct packed {
		logic      locked;		// filtered lock level
		logic      lock_lost;	// one cycle, when a stable lock drops
		loss_cnt_t loss_count;	// lock losses since rst
	} lock_status_t;

	// periodic timebase outputs
	// tick is one cycle at terminal count, pulse covers the last STRETCH+1 counts
	typedef struct packed {
		logic tick_1024;	// ~1024 Hz tick
		logic tick_30;		// ~30 Hz tick
		logic pulse_1024;	// stretched 1024 Hz pulse
		logic pulse_30;		// stretched 30 Hz pulse
	} timebase_t;

endpackage

/* src/timebase_top.sv */
// reset and timebase top beside the pll that drives sys_rst and the 1024 Hz and 30 Hz timebase
`timescale 1ns/100ps

module timebase_top import timebase_pkg::*; #(
	parameter int CLK_FREQ    = 20_000_000,	// sys_clk rate in Hz
	parameter int LOCK_FILTER = 8,			// stable-lock filter length
	parameter int HOLD_CYCLES = 20,			// reset hold after lock
	parameter int STRETCH     = 10			// stretched pulse width
) (
	input  logic         sys_clk,
	input  logic         rst,			// external reset, sync active high
	input  logic         pll_locked,	// raw pll lock level
	output logic         sys_rst,		// sequenced system reset
	output lock_status_t status,
	output timebase_t    timebase
);

	// period lengths in sys_clk cycles rounded down
	localparam tick_cnt_t DIV_1024 = tick_cnt_t'(CLK_FREQ / 1024);
	localparam tick_cnt_t DIV_30   = tick_cnt_t'(CLK_FREQ / 30);

	lock_status_t lock_stat;
	logic         tick_run;
	logic         tick_1024, pulse_1024;
	logic         tick_30, pulse_30;

	// ==================================================
	// lock and reset control
	// ==================================================
	lock_monitor #(.LOCK_FILTER(LOCK_FILTER)) u_lock_monitor (
		.sys_clk    (sys_clk),
		.rst        (rst),
		.pll_locked (pll_locked),
		.lock_stat  (lock_stat)
	);

	reset_sequencer #(.HOLD_CYCLES(HOLD_CYCLES)) u_reset_sequencer (
		.sys_clk   (sys_clk),
		.rst       (rst),
		.locked    (lock_stat.locked),
		.lock_lost (lock_stat.lock_lost),
		.sys_rst   (sys_rst),
		.tick_run  (tick_run)
	);

	// ==================================================
	// timebase generators
	// ==================================================
	tick_gen #(.DIVISOR(DIV_1024), .STRETCH(STRETCH)) u_tick_1024 (
		.sys_clk (sys_clk),
		.rst     (rst),
		.run     (tick_run),
		.tick    (tick_1024),
		.pulse   (pulse_1024)
	);

	tick_gen #(.DIVISOR(DIV_30), .STRETCH(STRETCH)) u_tick_30 (
		.sys_clk (sys_clk),
		.rst     (rst),
		.run     (tick_run),
		.tick    (tick_30),
		.pulse   (pulse_30)
	);

	assign status   = lock_stat;
	assign timebase = '{
		tick_1024:  tick_1024,
		tick_30:    tick_30,
		pulse_1024: pulse_1024,
		pulse_30:   pulse_30
	};

endmodule

/* sysclk_timebase.f */
src/timebase_pkg.sv
src/lock_monitor.sv
src/reset_sequencer.sv
src/tick_gen.sv
src/timebase_top.sv
test/timebase_sva.sv
test/timebase_tb.sv

/* test/timebase_sva.sv */
// concurrent checks on the reset sequencer and tick generators; attached to the DUT by bind
`timescale 1ns/100ps

module timebase_sva import timebase_pkg::*; (
	input logic       sys_clk,
	input logic       rst,
	input seq_state_t state,		// SEQ_RUN on tick_gen
	input logic       sys_rst,		// low on tick_gen
	input logic       run,
	input logic       tick			// low on the sequencer
);

	int unsigned fails = 0;		// summed by the testbench at the end

	// ==================================================
	// tick generator
	// ==================================================
	tick_single: assert property (@(posedge sys_clk) disable iff (rst) tick |=> !tick)
		else begin
			fails++;
			$error("tick high for two cycles in a row");
		end

	tick_needs_run: assert property (@(posedge sys_clk) disable iff (rst) !run |-> !tick)
		else begin
			fails++;
			$error("tick while run is low");
		end

	// ==================================================
	// reset sequencer
	// ==================================================
	rst_outside_run: assert property (@(posedge sys_clk) disable iff (rst)
		(state != SEQ_RUN) |-> sys_rst)
		else begin
			fails++;
			$error("sys_rst low outside SEQ_RUN");
		end

endmodule

bind reset_sequencer timebase_sva u_sva (
	.sys_clk (sys_clk),
	.rst     (rst),
	.state   (state),
	.sys_rst (sys_rst),
	.run     (tick_run),
	.tick    (1'b0)
);

bind tick_gen timebase_sva u_sva (
	.sys_clk (sys_clk),
	.rst     (rst),
	.state   (SEQ_RUN),
	.sys_rst (1'b0),
	.run     (run),
	.tick    (tick)
);

/* test/timebase_tb.sv */
// directed testbench that runs timebase_top through lock-up, timebase, loss and glitch tests
`timescale 1ns/100ps

module timebase_tb import timebase_pkg::*; ();

	localparam int CLK_FREQ    = 30720;
	localparam int LOCK_FILTER = 8;
	localparam int HOLD_CYCLES = 20;
	localparam int STRETCH     = 10;
	localparam int CLK_PERIOD  = 8;

	localparam int DIV_FAST = CLK_FREQ / 1024;	// 30 cycles
	localparam int DIV_SLOW = CLK_FREQ / 30;	// 1024 cycles

	// edges counted from the cycle pll_locked is driven
	localparam int LOCK_EDGES    = 1 + 2 + LOCK_FILTER;			// sample edge plus sync and filter
	localparam int RELEASE_EDGES = LOCK_EDGES + 1 + HOLD_CYCLES;	// leave wait then hold
	localparam int LOST_EDGE     = 1 + 2;						// locked falls and lock_lost pulses
	localparam int RESET_EDGE    = LOST_EDGE + 1;				// sequencer back in wait

	localparam int LOSS_ROUNDS = 3;
	localparam int GLITCHES    = 6;
	// j = 1023 mod 1024 and 29 mod 30 first meet at j = 15359
	localparam int SLOW_SPAN   = 15 * DIV_SLOW;

	// cycle budget for the watchdog
	localparam int BUDGET = 16 + 40 + RELEASE_EDGES + SLOW_SPAN
		+ LOSS_ROUNDS * (5 + RELEASE_EDGES + 2 * DIV_FAST)
		+ 16 + GLITCHES * (LOCK_FILTER + 4 + LOCK_EDGES);

	logic         sys_clk;
	logic         rst;
	logic         pll_locked;
	logic         sys_rst;
	lock_status_t status;
	timebase_t    timebase;

	integer seed;
	int     errors;
	int     checks;
	int     sva_fails;
	int     run_j;		// cycles since release and phase of both timebases

	timebase_top #(
		.CLK_FREQ    (CLK_FREQ),
		.LOCK_FILTER (LOCK_FILTER),
		.HOLD_CYCLES (HOLD_CYCLES),
		.STRETCH     (STRETCH)
	) DUT (
		.sys_clk    (sys_clk),
		.rst        (rst),
		.pll_locked (pll_locked),
		.sys_rst    (sys_rst),
		.status     (status),
		.timebase   (timebase)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// ==================================================
	// helpers and compare tasks
	// ==================================================
	task automatic next_cycle();
		@(posedge sys_clk);
		#1;		// outputs settled and inputs change here
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error @ %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_loss(input string what, input loss_cnt_t got, input loss_cnt_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error @ %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_timebase(input string what, input timebase_t got, input timebase_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error @ %0d ns: %s is %b, expected %b (t1024 t30 p1024 p30)",
				$time, what, got, exp);
		end
	endtask

	// count is j mod DIV plus 1 with tick at DIV and pulse from DIV-STRETCH on
	function automatic timebase_t expected_timebase(input int j);
		timebase_t exp_tb;
		exp_tb.tick_1024  = (j % DIV_FAST) == DIV_FAST - 1;
		exp_tb.pulse_1024 = (j % DIV_FAST) >= DIV_FAST - STRETCH - 1;
		exp_tb.tick_30    = (j % DIV_SLOW) == DIV_SLOW - 1;
		exp_tb.pulse_30   = (j % DIV_SLOW) >= DIV_SLOW - STRETCH - 1;
		return exp_tb;
	endfunction

	task automatic check_idle(input string what);
		check_bit({what, " locked"}, status.locked, 1'b0);
		check_bit({what, " lock_lost"}, status.lock_lost, 1'b0);
		check_loss({what, " loss_count"}, status.loss_count, '0);
		check_bit({what, " sys_rst"}, sys_rst, 1'b1);
		check_timebase({what, " timebase"}, timebase, '0);
	endtask

	task automatic track_running(input int n, input string what);
		repeat (n) begin
			next_cycle();
			run_j++;
			check_timebase(what, timebase, expected_timebase(run_j));
			check_bit({what, " sys_rst"}, sys_rst, 1'b0);
		end
	endtask

	task automatic apply_reset();
		rst        = 1'b1;
		pll_locked = 1'b0;
		repeat (16) next_cycle();
		rst = 1'b0;
	endtask

	// ==================================================
	// directed tests
	// ==================================================
	task automatic idle_after_reset();
		check_idle("after rst");
		repeat (40) begin
			next_cycle();
			check_idle("no lock");		// pll_locked still low
		end
	endtask

	task automatic lock_up();
		pll_locked = 1'b1;
		for (int n = 1; n <= RELEASE_EDGES; n++) begin
			next_cycle();
			check_bit("lock-up locked", status.locked, n >= LOCK_EDGES);
			check_bit("lock-up sys_rst", sys_rst, n < RELEASE_EDGES);
			check_bit("lock-up lock_lost", status.lock_lost, 1'b0);
			check_timebase("lock-up timebase", timebase, '0);
		end
		run_j = 0;	// release edge is phase 0
	endtask

	task automatic fast_timebase();
		track_running(6 * DIV_FAST, "fast timebase");
	endtask

	task automatic slow_timebase();
		int first_slow;
		int both;
		first_slow = -1;
		both       = 0;
		while (run_j < SLOW_SPAN) begin
			track_running(1, "slow timebase");
			if (timebase.tick_30 && first_slow < 0)
				first_slow = run_j;
			if (timebase.tick_30 && timebase.tick_1024)
				both++;
		end
		check_bit("first tick_30 at DIV_SLOW-1", first_slow == DIV_SLOW - 1, 1'b1);
		check_bit("ticks coincide exactly once", both == 1, 1'b1);
	endtask

	task automatic lock_loss();
		int        drop;
		loss_cnt_t exp_loss;
		exp_loss = '0;		// no loss since the last rst
		repeat (LOSS_ROUNDS) begin
			drop       = 1 + ({$random(seed)} % 5);
			pll_locked = 1'b0;
			for (int n = 1; n <= drop + RELEASE_EDGES; n++) begin
				next_cycle();
				check_bit("loss locked", status.locked,
					n < LOST_EDGE || n >= drop + LOCK_EDGES);
				check_bit("loss lock_lost", status.lock_lost, n == LOST_EDGE);
				check_loss("loss_count", status.loss_count,
					(n < LOST_EDGE) ? exp_loss : exp_loss + 1'b1);
				check_bit("loss sys_rst", sys_rst,
					n >= RESET_EDGE && n < drop + RELEASE_EDGES);
				if (n < RESET_EDGE) begin
					run_j++;	// still running until the sequencer reacts
					check_timebase("loss timebase", timebase, expected_timebase(run_j));
				end else begin
					check_timebase("loss timebase", timebase, '0);
				end
				if (n == drop)
					pll_locked = 1'b1;	// relock
			end
			exp_loss = exp_loss + 1'b1;	// one loss per round
			run_j    = 0;
			track_running(2 * DIV_FAST, "timebase after relock");
		end
	endtask

	task automatic glitch_filter();
		int width;
		int gap;
		apply_reset();
		check_loss("loss_count after rst", status.loss_count, '0);
		repeat (GLITCHES) begin
			width      = 1 + ({$random(seed)} % (LOCK_FILTER - 1));	// always short
			gap        = 1 + ({$random(seed)} % 4);
			pll_locked = 1'b1;
			repeat (width) begin
				next_cycle();
				check_idle("glitch high");
			end
			pll_locked = 1'b0;
			repeat (gap + LOCK_EDGES) begin
				next_cycle();
				check_idle("glitch low");
			end
		end
	endtask

	// ==================================================
	// main sequence and watchdog
	// ==================================================
	initial begin
		seed       = 90;
		errors     = 0;
		checks     = 0;
		run_j      = 0;
		rst        = 1'b1;
		pll_locked = 1'b0;
		apply_reset();
		idle_after_reset();
		lock_up();
		fast_timebase();
		slow_timebase();
		lock_loss();
		glitch_filter();
		sva_fails = DUT.u_reset_sequencer.u_sva.fails + DUT.u_tick_1024.u_sva.fails
			+ DUT.u_tick_30.u_sva.fails;
		$display("checks: %0d  errors: %0d  assertion failures: %0d",
			checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		#(2 * BUDGET * CLK_PERIOD);
		$display("timeout: the tests did not finish within twice their cycle budget");
		$display("TB FAILED");
		$finish;
	end

endmodule
